// File: hdl/sys_regs_pkg.sv
package sys_regs_pkg;

  localparam int WB_ADR_W    = 32;
  localparam int REG_IDX_LSB = 1;

  typedef logic [15:0] wb_data_t;
  typedef logic [1:0]  wb_sel_t;
  typedef logic [3:0]  reg_idx_t;
  typedef logic [15:0] irq_vec_t;

  // register index, taken from address bits 4 to 1
  localparam reg_idx_t REG_BOARD_ID     = 4'd0;
  localparam reg_idx_t REG_REV_MAJOR    = 4'd1;
  localparam reg_idx_t REG_REV_MINOR    = 4'd2;
  localparam reg_idx_t REG_REV_RCS      = 4'd3;
  localparam reg_idx_t REG_RCS_UPTODATE = 4'd4;
  localparam reg_idx_t REG_SCRATCHPAD1  = 4'd5;
  localparam reg_idx_t REG_SCRATCHPAD0  = 4'd6;
  localparam reg_idx_t REG_SOFT_RESET   = 4'd7;
  localparam reg_idx_t REG_USER_IRQ     = 4'd8;
  localparam reg_idx_t REG_MON_ADDR     = 4'd9;
  localparam reg_idx_t REG_MON_DATA     = 4'd10;
  localparam reg_idx_t REG_MON_STATUS   = 4'd11;
  localparam reg_idx_t REG_IRQ_PENDING  = 4'd12;
  localparam reg_idx_t REG_IRQ_MASK     = 4'd13;

  // board identity
  localparam wb_data_t BOARD_ID     = 16'h5b0d;
  localparam wb_data_t REV_MAJOR    = 16'h0002;
  localparam wb_data_t REV_MINOR    = 16'h0007;
  localparam wb_data_t REV_RCS      = 16'h01c3;
  localparam logic     RCS_UPTODATE = 1'b1;

  // expand byte-lane selects to a bit mask
  function automatic wb_data_t lane_mask(wb_sel_t sel);
    return {{8{sel[1]}}, {8{sel[0]}}};
  endfunction

  // update only the selected byte lanes of a word
  function automatic wb_data_t lane_merge(wb_data_t old_val, wb_data_t new_val,
                                          wb_sel_t sel);
    wb_data_t m;
    m = lane_mask(sel);
    return (old_val & ~m) | (new_val & m);
  endfunction

endpackage

// File: hdl/sysmon_pkg.sv
package sysmon_pkg;

  typedef logic [6:0]  mon_addr_t;
  typedef logic [15:0] mon_data_t;
  typedef logic [2:0]  adc_chan_t;
  typedef logic [5:0]  cfg_idx_t;

  localparam int NUM_CHAN    = 8;
  localparam int CONV_CYCLES = 16;
  localparam int CFG_WORDS   = 64;

  typedef logic [$clog2(CONV_CYCLES)-1:0] conv_cnt_t;

  // results at 0x00..0x07, rest of the lower half reads zero
  localparam mon_addr_t MON_RESULT_BASE = 7'h00;
  // configuration RAM at 0x40..0x7f
  localparam mon_addr_t MON_CFG_BASE    = 7'h40;

  // request side, driven by the system block
  typedef struct packed {
    logic      den;
    logic      dwe;
    mon_addr_t daddr;
    mon_data_t di;
  } drp_req_t;

  // response side, driven by the monitor
  typedef struct packed {
    logic      drdy;
    mon_data_t dout;
    logic      busy;
  } drp_rsp_t;

endpackage

// File: hdl/irq_ctrl.sv
module irq_ctrl
  import sys_regs_pkg::*;
(
  input  logic     wb_clk_i,
  input  logic     wb_rst_i,
  input  irq_vec_t app_irq_i,
  input  logic     pend_clr_i,
  input  logic     mask_wr_i,
  input  wb_data_t wr_data_i,
  input  wb_sel_t  wr_sel_i,
  output irq_vec_t pending_o,
  output irq_vec_t mask_o,
  output logic     irq_o
);

  irq_vec_t app_q;
  irq_vec_t rise;
  irq_vec_t clr;

  // previous line levels, so a line high at reset does not count as an edge
  always_ff @(posedge wb_clk_i) begin
    app_q <= app_irq_i;
  end

  assign rise = app_irq_i & ~app_q;

  // write 1 to clear, limited to the selected lanes
  assign clr = pend_clr_i ? (irq_vec_t'(wr_data_i) & irq_vec_t'(lane_mask(wr_sel_i))) : '0;

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      pending_o <= '0;
      mask_o    <= '0;
      irq_o     <= 1'b0;
    end else begin
      // a new edge beats a clear in the same cycle
      pending_o <= (pending_o & ~clr) | rise;
      if (mask_wr_i) begin
        mask_o <= irq_vec_t'(lane_merge(wb_data_t'(mask_o), wr_data_i, wr_sel_i));
      end
      // request follows the pending bits by one cycle
      irq_o <= |(pending_o & mask_o);
    end
  end

endmodule

// File: hdl/sysmon_drp.sv
module sysmon_drp
  import sysmon_pkg::*;
(
  input  logic      wb_clk_i,
  input  logic      wb_rst_i,
  input  drp_req_t  drp_req_i,
  output drp_rsp_t  drp_rsp_o,
  input  mon_data_t adc_sample_i,
  output adc_chan_t adc_chan_o
);

  typedef enum logic [1:0] {
    S_IDLE,
    S_ACCESS,
    S_RESP,
    S_LATE
  } rsp_state_t;

  rsp_state_t state;

  conv_cnt_t conv_cnt;
  adc_chan_t chan;
  logic      busy;
  logic      store_now;

  mon_data_t results [NUM_CHAN];
  mon_data_t cfg_ram [CFG_WORDS];

  logic      acc_we;
  mon_addr_t acc_addr;
  mon_data_t acc_di;
  mon_data_t rd_data;
  mon_addr_t res_off;
  cfg_idx_t  cfg_idx;
  logic      is_cfg;
  logic      is_result;

  // last cycle of a conversion
  assign store_now = (conv_cnt == conv_cnt_t'(CONV_CYCLES - 1));

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      conv_cnt <= '0;
      chan     <= '0;
      busy     <= 1'b0;
    end else begin
      busy <= 1'b1;
      if (store_now) begin
        conv_cnt <= '0;
        chan     <= (chan == adc_chan_t'(NUM_CHAN - 1)) ? '0 : chan + 1'b1;
      end else begin
        conv_cnt <= conv_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (store_now) begin
      results[chan] <= adc_sample_i;
    end
  end

  assign is_cfg    = (acc_addr >= MON_CFG_BASE);
  assign cfg_idx   = cfg_idx_t'(acc_addr - MON_CFG_BASE);
  assign res_off   = acc_addr - MON_RESULT_BASE;
  assign is_result = !is_cfg && (res_off < mon_addr_t'(NUM_CHAN));

  // the result store holds the port, so an answer due then slips a cycle
  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      state <= S_IDLE;
    end else begin
      case (state)
        S_IDLE:   if (drp_req_i.den) state <= S_ACCESS;
        S_ACCESS: state <= S_RESP;
        S_RESP:   state <= store_now ? S_LATE : S_IDLE;
        default:  state <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (state == S_IDLE && drp_req_i.den) begin
      acc_we   <= drp_req_i.dwe;
      acc_addr <= drp_req_i.daddr;
      acc_di   <= drp_req_i.di;
    end
    if (state == S_ACCESS) begin
      // result addresses are read only
      if (acc_we && is_cfg) begin
        cfg_ram[cfg_idx] <= acc_di;
      end
      if (is_cfg) begin
        rd_data <= cfg_ram[cfg_idx];
      end else if (is_result) begin
        rd_data <= results[adc_chan_t'(res_off)];
      end else begin
        rd_data <= '0;
      end
    end
  end

  assign drp_rsp_o.drdy = ((state == S_RESP) && !store_now) || (state == S_LATE);
  assign drp_rsp_o.dout = rd_data;
  assign drp_rsp_o.busy = busy;
  assign adc_chan_o     = chan;

endmodule

// File: hdl/sys_block.sv
module sys_block
  import sys_regs_pkg::*;
  import sysmon_pkg::*;
(
  input  logic                wb_clk_i,
  input  logic                wb_rst_i,
  input  logic                wb_cyc_i,
  input  logic                wb_stb_i,
  input  logic                wb_we_i,
  input  wb_sel_t             wb_sel_i,
  input  logic [WB_ADR_W-1:0] wb_adr_i,
  input  wb_data_t            wb_dat_i,
  output wb_data_t            wb_dat_o,
  output logic                wb_ack_o,
  output logic                soft_reset_o,
  output logic                irq_n_o,
  input  irq_vec_t            app_irq_i,
  input  mon_data_t           adc_sample_i,
  output adc_chan_t           adc_chan_o
);

  reg_idx_t  req_idx;
  reg_idx_t  rd_sel;
  logic      req;
  logic      req_wr;
  logic      mon_acc;

  logic [31:0] scratch_pad;
  logic        user_irq;

  // monitor window
  logic      mon_den;
  logic      mon_we;
  logic      mon_wait;
  mon_addr_t mon_addr;
  mon_data_t mon_data;
  drp_req_t  drp_req;
  drp_rsp_t  drp_rsp;

  irq_vec_t  irq_pending;
  irq_vec_t  irq_mask;
  logic      irq_req;

  assign req_idx = wb_adr_i[REG_IDX_LSB +: $bits(reg_idx_t)];
  // a request already being answered or waiting on the monitor is not taken again
  assign req     = wb_cyc_i & wb_stb_i & ~wb_ack_o & ~mon_wait;
  assign req_wr  = req & wb_we_i;
  assign mon_acc = (req_idx == REG_MON_DATA);

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      wb_ack_o     <= 1'b0;
      mon_den      <= 1'b0;
      mon_wait     <= 1'b0;
      soft_reset_o <= 1'b0;
      user_irq     <= 1'b1;
    end else begin
      wb_ack_o <= (req & ~mon_acc) | (mon_wait & drp_rsp.drdy);
      mon_den  <= req & mon_acc;
      if (req && mon_acc) begin
        mon_wait <= 1'b1;
      end else if (drp_rsp.drdy) begin
        mon_wait <= 1'b0;
      end
      if (req_wr && wb_sel_i[0]) begin
        if (req_idx == REG_SOFT_RESET) begin
          soft_reset_o <= wb_dat_i[0];
        end
        if (req_idx == REG_USER_IRQ) begin
          user_irq <= wb_dat_i[0];
        end
      end
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (req) begin
      rd_sel <= req_idx;
    end
    if (req && mon_acc) begin
      mon_we <= wb_we_i;
    end
    if (req_wr) begin
      case (req_idx)
        REG_SCRATCHPAD1: scratch_pad[31:16] <= lane_merge(scratch_pad[31:16], wb_dat_i, wb_sel_i);
        REG_SCRATCHPAD0: scratch_pad[15:0]  <= lane_merge(scratch_pad[15:0], wb_dat_i, wb_sel_i);
        REG_MON_ADDR: begin
          if (wb_sel_i[0]) begin
            mon_addr <= wb_dat_i[6:0];
          end
        end
        REG_MON_DATA:    mon_data <= lane_merge(mon_data, wb_dat_i, wb_sel_i);
        default: ;
      endcase
    end
    // read data lands together with ack
    if (mon_wait && drp_rsp.drdy && !mon_we) begin
      mon_data <= drp_rsp.dout;
    end
  end

  always_comb begin
    case (rd_sel)
      REG_BOARD_ID:     wb_dat_o = BOARD_ID;
      REG_REV_MAJOR:    wb_dat_o = REV_MAJOR;
      REG_REV_MINOR:    wb_dat_o = REV_MINOR;
      REG_REV_RCS:      wb_dat_o = REV_RCS;
      REG_RCS_UPTODATE: wb_dat_o = wb_data_t'(RCS_UPTODATE);
      REG_SCRATCHPAD1:  wb_dat_o = scratch_pad[31:16];
      REG_SCRATCHPAD0:  wb_dat_o = scratch_pad[15:0];
      REG_SOFT_RESET:   wb_dat_o = wb_data_t'(soft_reset_o);
      REG_USER_IRQ:     wb_dat_o = wb_data_t'(user_irq);
      REG_MON_ADDR:     wb_dat_o = wb_data_t'(mon_addr);
      REG_MON_DATA:     wb_dat_o = mon_data;
      REG_MON_STATUS:   wb_dat_o = wb_data_t'(drp_rsp.busy);
      REG_IRQ_PENDING:  wb_dat_o = irq_pending;
      REG_IRQ_MASK:     wb_dat_o = irq_mask;
      default:          wb_dat_o = '0;
    endcase
  end

  // user bit low forces the interrupt
  assign irq_n_o = user_irq & ~irq_req;

  assign drp_req.den   = mon_den;
  assign drp_req.dwe   = mon_we;
  assign drp_req.daddr = mon_addr;
  assign drp_req.di    = mon_data;

  sysmon_drp u_sysmon (
    .wb_clk_i     (wb_clk_i),
    .wb_rst_i     (wb_rst_i),
    .drp_req_i    (drp_req),
    .drp_rsp_o    (drp_rsp),
    .adc_sample_i (adc_sample_i),
    .adc_chan_o   (adc_chan_o)
  );

  irq_ctrl u_irq (
    .wb_clk_i   (wb_clk_i),
    .wb_rst_i   (wb_rst_i),
    .app_irq_i  (app_irq_i),
    .pend_clr_i (req_wr && (req_idx == REG_IRQ_PENDING)),
    .mask_wr_i  (req_wr && (req_idx == REG_IRQ_MASK)),
    .wr_data_i  (wb_dat_i),
    .wr_sel_i   (wb_sel_i),
    .pending_o  (irq_pending),
    .mask_o     (irq_mask),
    .irq_o      (irq_req)
  );

endmodule

// File: hdl/sys_top.sv
module sys_top
  import sys_regs_pkg::*;
  import sysmon_pkg::*;
(
  input  logic                wb_clk_i,
  input  logic                wb_rst_i,
  input  logic                wb_cyc_i,
  input  logic                wb_stb_i,
  input  logic                wb_we_i,
  input  wb_sel_t             wb_sel_i,
  input  logic [WB_ADR_W-1:0] wb_adr_i,
  input  wb_data_t            wb_dat_i,
  output wb_data_t            wb_dat_o,
  output logic                wb_ack_o,
  output logic                soft_reset_o,
  output logic                irq_n_o,
  input  irq_vec_t            app_irq_i,
  input  mon_data_t           adc_sample_i,
  output adc_chan_t           adc_chan_o
);

  sys_block u_sys_block (
    .wb_clk_i     (wb_clk_i),
    .wb_rst_i     (wb_rst_i),
    .wb_cyc_i     (wb_cyc_i),
    .wb_stb_i     (wb_stb_i),
    .wb_we_i      (wb_we_i),
    .wb_sel_i     (wb_sel_i),
    .wb_adr_i     (wb_adr_i),
    .wb_dat_i     (wb_dat_i),
    .wb_dat_o     (wb_dat_o),
    .wb_ack_o     (wb_ack_o),
    .soft_reset_o (soft_reset_o),
    .irq_n_o      (irq_n_o),
    .app_irq_i    (app_irq_i),
    .adc_sample_i (adc_sample_i),
    .adc_chan_o   (adc_chan_o)
  );

endmodule

// File: tests/tb_clock.sv
module tb_clock #(
  parameter int PERIOD = 4
) (
  output logic clk_o
);

  initial begin
    clk_o = 1'b0;
  end

  always #(PERIOD / 2) clk_o = ~clk_o;

endmodule

// File: tests/tb_checker.sv
module tb_checker
  import sys_regs_pkg::*;
  import sysmon_pkg::*;
#(
  parameter logic [16*NUM_CHAN-1:0] ADC_TABLE = '0
) (
  input logic        wb_clk_i,
  input logic        wb_rst_i,
  input logic        wb_cyc_i,
  input logic        wb_stb_i,
  input logic        wb_we_i,
  input wb_sel_t     wb_sel_i,
  input logic [31:0] wb_adr_i,
  input wb_data_t    wb_dat_i,
  input wb_data_t    wb_dat_o_i,
  input logic        wb_ack_i,
  input logic        soft_reset_i,
  input logic        irq_n_i,
  input irq_vec_t    app_irq_i,
  input adc_chan_t   adc_chan_i
);

  int chk_cnt  = 0;
  int err_cnt  = 0;
  int test_chk = 0;
  int test_err = 0;

  // reference model state
  logic        soft_m;
  logic        user_m;
  logic        irq_req_m;
  irq_vec_t    pend_m;
  irq_vec_t    mask_m;
  irq_vec_t    app_q_m;
  mon_addr_t   mon_addr_m;
  mon_data_t   mon_data_m;
  logic [31:0] scratch_m;
  mon_data_t   cfg_m [CFG_WORDS];
  logic        cfg_ok [CFG_WORDS];
  adc_chan_t   chan_m;
  int          conv_m;

  // access in flight
  logic      in_acc;
  logic      acc_we;
  reg_idx_t  acc_idx;
  int        acc_wait;
  int        up_cycles;

  initial begin
    for (int i = 0; i < CFG_WORDS; i++) begin
      cfg_ok[i] = 1'b0;
    end
  end

  function automatic wb_data_t merge_lanes(wb_data_t old_val, wb_data_t new_val, wb_sel_t sel);
    wb_data_t res;
    res = old_val;
    if (sel[0]) begin
      res[7:0] = new_val[7:0];
    end
    if (sel[1]) begin
      res[15:8] = new_val[15:8];
    end
    return res;
  endfunction

  task automatic check_value(string what, wb_data_t got, wb_data_t exp);
    chk_cnt++;
    test_chk++;
    if (got !== exp) begin
      err_cnt++;
      test_err++;
      $display("** Error at time %0t: %s expected %h got %h", $time, what, exp, got);
    end
  endtask

  task automatic report_failure(string what);
    err_cnt++;
    test_err++;
    $display("failure at time %0t: %s", $time, what);
  endtask

  task automatic end_test(string name);
    $display("%s: %0d checks, %0d errors", name, test_chk, test_err);
    test_chk = 0;
    test_err = 0;
  endtask

  task automatic check_read(reg_idx_t idx, wb_data_t got);
    logic     known;
    wb_data_t exp;
    cfg_idx_t ci;
    known = 1'b1;
    exp   = '0;
    case (idx)
      REG_BOARD_ID:     exp = BOARD_ID;
      REG_REV_MAJOR:    exp = REV_MAJOR;
      REG_REV_MINOR:    exp = REV_MINOR;
      REG_REV_RCS:      exp = REV_RCS;
      REG_RCS_UPTODATE: exp = wb_data_t'(RCS_UPTODATE);
      REG_SCRATCHPAD1:  exp = scratch_m[31:16];
      REG_SCRATCHPAD0:  exp = scratch_m[15:0];
      REG_SOFT_RESET:   exp = wb_data_t'(soft_m);
      REG_USER_IRQ:     exp = wb_data_t'(user_m);
      REG_MON_ADDR:     exp = wb_data_t'(mon_addr_m);
      // the sequencer starts converting right after reset
      REG_MON_STATUS:   exp = 16'h0001;
      REG_IRQ_PENDING:  exp = pend_m;
      REG_IRQ_MASK:     exp = mask_m;
      REG_MON_DATA: begin
        if (mon_addr_m >= MON_CFG_BASE) begin
          ci    = cfg_idx_t'(mon_addr_m - MON_CFG_BASE);
          known = cfg_ok[ci];
          exp   = cfg_m[ci];
        end else if (mon_addr_m < mon_addr_t'(NUM_CHAN)) begin
          // results only hold table values after one full sweep
          known = (up_cycles > NUM_CHAN * CONV_CYCLES + 4);
          exp   = ADC_TABLE[int'(mon_addr_m) * 16 +: 16];
        end else begin
          exp = '0;
        end
        mon_data_m = known ? exp : 'x;
      end
      default: exp = '0;
    endcase
    if (known) begin
      check_value($sformatf("read of register %0d", idx), got, exp);
    end
  endtask

  task automatic apply_write(reg_idx_t idx, wb_data_t dat, wb_sel_t sel);
    case (idx)
      REG_SCRATCHPAD1: scratch_m[31:16] = merge_lanes(scratch_m[31:16], dat, sel);
      REG_SCRATCHPAD0: scratch_m[15:0]  = merge_lanes(scratch_m[15:0], dat, sel);
      REG_SOFT_RESET:  if (sel[0]) soft_m = dat[0];
      REG_USER_IRQ:    if (sel[0]) user_m = dat[0];
      REG_MON_ADDR:    if (sel[0]) mon_addr_m = dat[6:0];
      REG_IRQ_MASK:    mask_m = merge_lanes(mask_m, dat, sel);
      REG_MON_DATA: begin
        mon_data_m = merge_lanes(mon_data_m, dat, sel);
        // result addresses are read only
        if (mon_addr_m >= MON_CFG_BASE) begin
          cfg_m[cfg_idx_t'(mon_addr_m - MON_CFG_BASE)]  = mon_data_m;
          cfg_ok[cfg_idx_t'(mon_addr_m - MON_CFG_BASE)] = 1'b1;
        end
      end
      default: ;
    endcase
  endtask

  always @(posedge wb_clk_i) begin
    logic     accept;
    reg_idx_t idx;
    irq_vec_t clr;
    if (wb_rst_i) begin
      soft_m    = 1'b0;
      user_m    = 1'b1;
      irq_req_m = 1'b0;
      pend_m    = '0;
      mask_m    = '0;
      in_acc    = 1'b0;
      up_cycles = 0;
      chan_m    = '0;
      conv_m    = 0;
    end else begin
      check_value("soft_reset_o", wb_data_t'(soft_reset_i), wb_data_t'(soft_m));
      check_value("irq_n_o", wb_data_t'(irq_n_i), wb_data_t'(user_m & ~irq_req_m));
      check_value("adc_chan_o", wb_data_t'(adc_chan_i), wb_data_t'(chan_m));
      if (wb_ack_i) begin
        if (!in_acc) begin
          report_failure("ack seen without a pending request");
        end else if (!acc_we) begin
          check_read(acc_idx, wb_dat_o_i);
        end
        in_acc = 1'b0;
      end else if (in_acc) begin
        acc_wait++;
        if (acc_wait > 32) begin
          report_failure($sformatf("no ack for access to register %0d", acc_idx));
          in_acc = 1'b0;
        end
      end
      accept = wb_cyc_i && wb_stb_i && !wb_ack_i && !in_acc;
      idx    = wb_adr_i[4:1];
      clr    = '0;
      if (accept && wb_we_i && idx == REG_IRQ_PENDING) begin
        clr = merge_lanes('0, wb_dat_i, wb_sel_i);
      end
      // interrupt request lags the pending bits by one cycle
      irq_req_m = |(pend_m & mask_m);
      pend_m    = (pend_m & ~clr) | (app_irq_i & ~app_q_m);
      if (accept) begin
        in_acc   = 1'b1;
        acc_we   = wb_we_i;
        acc_idx  = idx;
        acc_wait = 0;
        if (wb_we_i) begin
          apply_write(idx, wb_dat_i, wb_sel_i);
        end
      end
      // channel moves on after the last conversion cycle
      if (conv_m == CONV_CYCLES - 1) begin
        conv_m = 0;
        chan_m = adc_chan_t'((int'(chan_m) + 1) % NUM_CHAN);
      end else begin
        conv_m++;
      end
      up_cycles++;
    end
    app_q_m = app_irq_i;
  end

endmodule

// File: tests/tb_top.sv
module tb_top
  import sys_regs_pkg::*;
  import sysmon_pkg::*;
;

  // sample per channel, channel 0 in the low word
  localparam logic [16*NUM_CHAN-1:0] ADC_TABLE = {
    16'h6d14, 16'h0b7e, 16'hc3a9, 16'h4410, 16'h9f02, 16'h2e85, 16'h7131, 16'h05c6
  };
  localparam int N_ACCESS    = 264;
  localparam int CYCLE_LIMIT = N_ACCESS * 8 + 2000;

  logic        clk;
  logic        rst;
  logic        cyc;
  logic        stb;
  logic        we;
  wb_sel_t     sel;
  logic [31:0] adr;
  wb_data_t    dat_w;
  wb_data_t    dat_r;
  logic        ack;
  logic        soft_reset;
  logic        irq_n;
  irq_vec_t    app_irq;
  mon_data_t   adc_sample;
  adc_chan_t   adc_chan;

  logic [31:0] lfsr = 32'h2a58cec9;
  int          cycle_cnt = 0;
  mon_addr_t   cfg_addrs [$];

  tb_clock #(.PERIOD(4)) u_clk (.clk_o(clk));

  sys_top u_dut (
    .wb_clk_i     (clk),
    .wb_rst_i     (rst),
    .wb_cyc_i     (cyc),
    .wb_stb_i     (stb),
    .wb_we_i      (we),
    .wb_sel_i     (sel),
    .wb_adr_i     (adr),
    .wb_dat_i     (dat_w),
    .wb_dat_o     (dat_r),
    .wb_ack_o     (ack),
    .soft_reset_o (soft_reset),
    .irq_n_o      (irq_n),
    .app_irq_i    (app_irq),
    .adc_sample_i (adc_sample),
    .adc_chan_o   (adc_chan)
  );

  tb_checker #(.ADC_TABLE(ADC_TABLE)) u_chk (
    .wb_clk_i     (clk),
    .wb_rst_i     (rst),
    .wb_cyc_i     (cyc),
    .wb_stb_i     (stb),
    .wb_we_i      (we),
    .wb_sel_i     (sel),
    .wb_adr_i     (adr),
    .wb_dat_i     (dat_w),
    .wb_dat_o_i   (dat_r),
    .wb_ack_i     (ack),
    .soft_reset_i (soft_reset),
    .irq_n_i      (irq_n),
    .app_irq_i    (app_irq),
    .adc_chan_i   (adc_chan)
  );

  // galois lfsr, one step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v    = {v[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
    end
    return v;
  endfunction

  task automatic bus_access(input logic w, input reg_idx_t idx, input wb_data_t d,
                            input wb_sel_t s);
    @(negedge clk);
    cyc   = 1'b1;
    stb   = 1'b1;
    we    = w;
    adr   = {27'd0, idx, 1'b0};
    dat_w = d;
    sel   = s;
    do @(negedge clk); while (ack !== 1'b1);
    cyc = 1'b0;
    stb = 1'b0;
    we  = 1'b0;
  endtask

  task automatic write_reg(input reg_idx_t idx, input wb_data_t d, input wb_sel_t s);
    bus_access(1'b1, idx, d, s);
  endtask

  task automatic read_reg(input reg_idx_t idx);
    bus_access(1'b0, idx, '0, 2'b11);
  endtask

  // sample follows the selected channel
  always @(negedge clk) begin
    adc_sample = ADC_TABLE[int'(adc_chan) * 16 +: 16];
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt == CYCLE_LIMIT) begin
      $display("run timed out after %0d cycles", cycle_cnt);
      $display("Test FAILED");
      $finish;
    end
  end

  initial begin
    mon_addr_t a;
    cyc        = 1'b0;
    stb        = 1'b0;
    we         = 1'b0;
    sel        = '0;
    adr        = '0;
    dat_w      = '0;
    app_irq    = '0;
    adc_sample = '0;
    rst        = 1'b1;
    repeat (10) @(negedge clk);
    rst = 1'b0;

    for (int i = 0; i < 16; i++) begin
      read_reg(reg_idx_t'(i));
    end
    u_chk.end_test("identity registers");

    write_reg(REG_SCRATCHPAD1, wb_data_t'(rand_bits(16)), 2'b11);
    write_reg(REG_SCRATCHPAD0, wb_data_t'(rand_bits(16)), 2'b11);
    for (int i = 0; i < 40; i++) begin
      write_reg(rand_bits(1) ? REG_SCRATCHPAD1 : REG_SCRATCHPAD0,
                wb_data_t'(rand_bits(16)), wb_sel_t'(rand_bits(2)));
      read_reg(rand_bits(1) ? REG_SCRATCHPAD1 : REG_SCRATCHPAD0);
    end
    u_chk.end_test("scratch pad");

    for (int i = 0; i < 8; i++) begin
      write_reg(REG_SOFT_RESET, wb_data_t'(rand_bits(16)), wb_sel_t'(rand_bits(2)));
      read_reg(REG_SOFT_RESET);
      write_reg(REG_USER_IRQ, wb_data_t'(rand_bits(16)), wb_sel_t'(rand_bits(2)));
      read_reg(REG_USER_IRQ);
    end
    write_reg(REG_SOFT_RESET, 16'h0000, 2'b11);
    write_reg(REG_USER_IRQ, 16'h0001, 2'b11);
    u_chk.end_test("soft reset and user irq");

    for (int i = 0; i < 16; i++) begin
      a = MON_CFG_BASE | mon_addr_t'(rand_bits(6));
      cfg_addrs.push_back(a);
      write_reg(REG_MON_ADDR, wb_data_t'(a), 2'b11);
      write_reg(REG_MON_DATA, wb_data_t'(rand_bits(16)), 2'b11);
    end
    foreach (cfg_addrs[i]) begin
      write_reg(REG_MON_ADDR, wb_data_t'(cfg_addrs[i]), 2'b11);
      read_reg(REG_MON_DATA);
    end
    // one full sweep over all channels
    repeat (NUM_CHAN * CONV_CYCLES + 8) @(negedge clk);
    for (int ch = 0; ch < NUM_CHAN; ch++) begin
      write_reg(REG_MON_ADDR, wb_data_t'(ch), 2'b11);
      write_reg(REG_MON_DATA, wb_data_t'(rand_bits(16)), 2'b11);
      read_reg(REG_MON_DATA);
    end
    write_reg(REG_MON_ADDR, 16'h0020, 2'b11);
    read_reg(REG_MON_DATA);
    u_chk.end_test("system monitor");

    for (int i = 0; i < 6; i++) begin
      write_reg(REG_IRQ_MASK, wb_data_t'(rand_bits(16)), 2'b11);
      app_irq = '0;
      repeat (2) @(negedge clk);
      app_irq = irq_vec_t'(rand_bits(16));
      repeat (4) @(negedge clk);
      read_reg(REG_IRQ_PENDING);
      read_reg(REG_IRQ_MASK);
      write_reg(REG_IRQ_PENDING, 16'hffff, wb_sel_t'(rand_bits(2)));
      read_reg(REG_IRQ_PENDING);
      write_reg(REG_IRQ_PENDING, 16'hffff, 2'b11);
      read_reg(REG_IRQ_PENDING);
      app_irq = '0;
    end
    u_chk.end_test("interrupt controller");

    $display("%0d checks, %0d errors", u_chk.chk_cnt, u_chk.err_cnt);
    if (u_chk.err_cnt == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

// File: src.f
hdl/sys_regs_pkg.sv
hdl/sysmon_pkg.sv
hdl/irq_ctrl.sv
hdl/sysmon_drp.sv
hdl/sys_block.sv
hdl/sys_top.sv
tests/tb_clock.sv
tests/tb_checker.sv
tests/tb_top.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --top-module tb_top -f src.f -o tb_sim
	@out="$$(./obj_dir/tb_sim)"; echo "$$out"; echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf obj_dir
